// File: hdl/axi_sw_settings.svh
////////////////////
// Sizes and depths of the AXI write switch
// Included by the packages and by every module that sizes a FIFO or counter
////////////////////

`ifndef AXI_SW_SETTINGS_SVH
`define AXI_SW_SETTINGS_SVH

// Channel widths
`define SW_ADDR_W     16
`define SW_ID_W       4
`define SW_DATA_W     32

// Slave count, queue depths and per-slave credit limit
`define SW_SLV_NB     4
`define SW_TGT_DEPTH  8
`define SW_MR_DEPTH   4
`define SW_MAX_OUTST  3

`endif

// File: hdl/axi_chan_pkg.sv
////////////////////
// AXI write channel field types and the response code
////////////////////

`include "axi_sw_settings.svh"

package axi_chan_pkg;

    typedef logic [`SW_ADDR_W-1:0] addr_t;
    typedef logic [`SW_ID_W-1:0]   id_t;
    typedef logic [`SW_DATA_W-1:0] data_t;

    // BRESP encoding
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        EXOKAY = 2'd1,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } resp_e;

endpackage

// File: hdl/sw_map_pkg.sv
////////////////////
// Slave memory map and route mask of the single master
////////////////////

`include "axi_sw_settings.svh"

package sw_map_pkg;

    typedef logic [`SW_SLV_NB-1:0] slv_mask_t;
    typedef logic [1:0]            slv_idx_t;

    // Slave k owns k*0x1000 up to k*0x1000+0xFFF
    localparam axi_chan_pkg::addr_t SLV_START [0:`SW_SLV_NB-1] = '{
        16'h0000, 16'h1000, 16'h2000, 16'h3000
    };

    localparam axi_chan_pkg::addr_t SLV_END [0:`SW_SLV_NB-1] = '{
        16'h0FFF, 16'h1FFF, 16'h2FFF, 16'h3FFF
    };

    // Slave 3 is off limits, 0x4000 and up maps nowhere
    localparam slv_mask_t ROUTE_MASK = 4'b0111;

endpackage

// File: hdl/slv_lane_if.sv
////////////////////
// Handshake bundle of one slave lane
////////////////////

`timescale 1ns/100ps

interface slv_lane_if;

    logic aw_valid;
    logic aw_ready;
    logic w_valid;
    logic w_ready;
    logic w_last;
    logic b_valid;
    logic b_ready;

    // Decoder side, lane side and response arbiter side
    modport route (output aw_valid, output w_valid, output w_last,
                   input aw_ready, input w_ready);
    modport lane  (input aw_valid, input w_valid, input w_last, input b_ready,
                   output aw_ready, output w_ready, output b_valid);
    modport resp  (input b_valid, output b_ready);

endinterface

// File: hdl/sync_fifo.sv
////////////////////
// Register-array FIFO, DEPTH must be a power of two
////////////////////

`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             i_push,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_pull,
    output logic [WIDTH-1:0] o_data,
    output logic             o_full,
    output logic             o_empty
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [0:DEPTH-1];
    // Extra top bit tells full from empty
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;
    logic             do_push;
    logic             do_pull;

    assign do_push = i_push & ~o_full;
    assign do_pull = i_pull & ~o_empty;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + (PTR_W+1)'(1);
            if (do_pull)
                rd_ptr <= rd_ptr + (PTR_W+1)'(1);
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push)
            mem[wr_ptr[PTR_W-1:0]] <= i_data;
    end

    assign o_data  = mem[rd_ptr[PTR_W-1:0]];
    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

endmodule

// File: hdl/aw_route_decode.sv
////////////////////
// Write address decode and write data steering toward the slave lanes
////////////////////

`timescale 1ns/100ps
`include "axi_sw_settings.svh"

module aw_route_decode (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                i_awvalid,
    input  axi_chan_pkg::addr_t i_awaddr,
    input  axi_chan_pkg::id_t   i_awid,
    input  logic                i_wvalid,
    input  logic                i_wlast,
    input  logic                i_mr_full,
    output logic                o_awready,
    output logic                o_wready,
    output logic                o_mr_push,
    output axi_chan_pkg::id_t   o_mr_id,
    slv_lane_if.route           lane_if [0:`SW_SLV_NB-1]
);

    sw_map_pkg::slv_mask_t aw_sel;
    sw_map_pkg::slv_mask_t lane_awready;
    sw_map_pkg::slv_mask_t lane_wready;
    sw_map_pkg::slv_mask_t tgt_head;
    logic                  tgt_full;
    logic                  tgt_empty;
    logic                  mr_accept;

    ////////////////////
    // AW channel
    ////////////////////

    for (genvar k = 0; k < `SW_SLV_NB; k++) begin : g_lane
        assign aw_sel[k] = sw_map_pkg::ROUTE_MASK[k] &&
                           (i_awaddr >= sw_map_pkg::SLV_START[k]) &&
                           (i_awaddr <= sw_map_pkg::SLV_END[k]);
        // Hold valid back while no FIFO slot is free for the target
        assign lane_if[k].aw_valid = i_awvalid & aw_sel[k] & ~tgt_full;
        assign lane_awready[k]     = lane_if[k].aw_ready;
        assign lane_if[k].w_valid  = i_wvalid & tgt_head[k] & ~tgt_empty;
        assign lane_if[k].w_last   = i_wlast & tgt_head[k] & ~tgt_empty;
        assign lane_wready[k]      = lane_if[k].w_ready;
    end

    // Fake accept for unmapped or forbidden addresses, one cycle wide
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            mr_accept <= 1'b0;
        else if (mr_accept)
            mr_accept <= 1'b0;
        else
            mr_accept <= i_awvalid & ~(|aw_sel) & ~i_mr_full & ~tgt_full;
    end

    assign o_awready = (|aw_sel) ? ((|(aw_sel & lane_awready)) & ~tgt_full) : mr_accept;
    assign o_mr_push = mr_accept;
    assign o_mr_id   = i_awid;

    ////////////////////
    // W channel
    ////////////////////

    // Target of each accepted AW, all-zero for a misroute
    sync_fifo #(
        .WIDTH ($bits(sw_map_pkg::slv_mask_t)),
        .DEPTH (`SW_TGT_DEPTH)
    ) u_tgt_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_push  (i_awvalid & o_awready),
        .i_data  (aw_sel),
        .i_pull  (i_wvalid & o_wready & i_wlast),
        .o_data  (tgt_head),
        .o_full  (tgt_full),
        .o_empty (tgt_empty)
    );

    // Misrouted data is swallowed
    assign o_wready = ~tgt_empty & ((|tgt_head) ? (|(tgt_head & lane_wready)) : 1'b1);

endmodule

// File: hdl/slv_lane.sv
////////////////////
// One slave port, limits the writes left unanswered by that slave
////////////////////

`timescale 1ns/100ps
`include "axi_sw_settings.svh"

module slv_lane (
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      i_awready,
    input  logic      i_wready,
    input  logic      i_bvalid,
    output logic      o_awvalid,
    output logic      o_wvalid,
    output logic      o_wlast,
    output logic      o_bready,
    slv_lane_if.lane  lane_if
);

    localparam int CNT_W = $clog2(`SW_MAX_OUTST + 1);

    logic [CNT_W-1:0] outst;
    logic             credit_out;
    logic             aw_xfer;
    logic             b_xfer;

    assign credit_out = (outst == CNT_W'(`SW_MAX_OUTST));

    // Slave sees no AW once its credits are used up
    assign o_awvalid        = lane_if.aw_valid & ~credit_out;
    assign lane_if.aw_ready = i_awready & ~credit_out;

    assign o_wvalid        = lane_if.w_valid;
    assign o_wlast         = lane_if.w_last;
    assign lane_if.w_ready = i_wready;

    assign lane_if.b_valid = i_bvalid;
    assign o_bready        = lane_if.b_ready;

    assign aw_xfer = o_awvalid & i_awready;
    assign b_xfer  = i_bvalid & o_bready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn)
            outst <= '0;
        else if (aw_xfer && !b_xfer)
            outst <= outst + CNT_W'(1);
        else if (b_xfer && !aw_xfer)
            outst <= outst - CNT_W'(1);
    end

endmodule

// File: hdl/bresp_arbiter.sv
////////////////////
// Round-robin merge of slave write responses, DECERR for misroutes first
////////////////////

`timescale 1ns/100ps
`include "axi_sw_settings.svh"

module bresp_arbiter (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                i_mr_push,
    input  axi_chan_pkg::id_t   i_mr_id,
    input  logic                i_bready,
    input  axi_chan_pkg::id_t   i_s_bid   [0:`SW_SLV_NB-1],
    input  axi_chan_pkg::resp_e i_s_bresp [0:`SW_SLV_NB-1],
    output logic                o_mr_full,
    output logic                o_bvalid,
    output axi_chan_pkg::id_t   o_bid,
    output axi_chan_pkg::resp_e o_bresp,
    slv_lane_if.resp            resp_if [0:`SW_SLV_NB-1]
);

    sw_map_pkg::slv_mask_t req;
    sw_map_pkg::slv_idx_t  rr_ptr;
    sw_map_pkg::slv_idx_t  pick_idx;
    sw_map_pkg::slv_idx_t  sel_idx;
    sw_map_pkg::slv_idx_t  hold_idx;
    logic                  hold_vld;
    logic                  hold_mr;
    logic                  use_mr;
    logic                  mr_empty;
    axi_chan_pkg::id_t     mr_id;

    // IDs of misrouted writes waiting for their DECERR
    sync_fifo #(
        .WIDTH ($bits(axi_chan_pkg::id_t)),
        .DEPTH (`SW_MR_DEPTH)
    ) u_mr_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_push  (i_mr_push),
        .i_data  (i_mr_id),
        .i_pull  (o_bvalid & i_bready & use_mr),
        .o_data  (mr_id),
        .o_full  (o_mr_full),
        .o_empty (mr_empty)
    );

    for (genvar k = 0; k < `SW_SLV_NB; k++) begin : g_req
        assign req[k] = resp_if[k].b_valid;
        assign resp_if[k].b_ready = ~use_mr & i_bready &
                                    (sel_idx == sw_map_pkg::slv_idx_t'(k));
    end

    // First requester at or after the pointer
    always_comb begin
        pick_idx = rr_ptr;
        for (int i = `SW_SLV_NB - 1; i >= 0; i--) begin
            if (req[rr_ptr + sw_map_pkg::slv_idx_t'(i)])
                pick_idx = rr_ptr + sw_map_pkg::slv_idx_t'(i);
        end
    end

    // A response left waiting keeps its source
    assign use_mr   = hold_vld ? hold_mr : ~mr_empty;
    assign sel_idx  = hold_vld ? hold_idx : pick_idx;
    assign o_bvalid = use_mr | req[sel_idx];

    always_comb begin
        if (use_mr) begin
            o_bid   = mr_id;
            o_bresp = axi_chan_pkg::DECERR;
        end else begin
            o_bid   = i_s_bid[sel_idx];
            o_bresp = i_s_bresp[sel_idx];
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            hold_vld <= 1'b0;
            hold_mr  <= 1'b0;
            hold_idx <= '0;
            rr_ptr   <= '0;
        end else begin
            hold_vld <= o_bvalid & ~i_bready;
            hold_mr  <= use_mr;
            hold_idx <= sel_idx;
            // Move past the lane just served
            if (o_bvalid && i_bready && !use_mr)
                rr_ptr <= sel_idx + sw_map_pkg::slv_idx_t'(1);
        end
    end

endmodule

// File: hdl/axi_wr_switch.sv
////////////////////
// One-master, four-slave AXI write switch, top level
////////////////////

`timescale 1ns/100ps
`include "axi_sw_settings.svh"

module axi_wr_switch (
    input  logic                  aclk,
    input  logic                  aresetn,
    // Master side
    input  logic                  i_m_awvalid,
    input  axi_chan_pkg::addr_t   i_m_awaddr,
    input  axi_chan_pkg::id_t     i_m_awid,
    input  logic                  i_m_wvalid,
    input  logic                  i_m_wlast,
    input  axi_chan_pkg::data_t   i_m_wdata,
    input  logic                  i_m_bready,
    output logic                  o_m_awready,
    output logic                  o_m_wready,
    output logic                  o_m_bvalid,
    output axi_chan_pkg::id_t     o_m_bid,
    output axi_chan_pkg::resp_e   o_m_bresp,
    // Slave side
    output sw_map_pkg::slv_mask_t o_s_awvalid,
    output axi_chan_pkg::addr_t   o_s_awaddr,
    output axi_chan_pkg::id_t     o_s_awid,
    output sw_map_pkg::slv_mask_t o_s_wvalid,
    output sw_map_pkg::slv_mask_t o_s_wlast,
    output axi_chan_pkg::data_t   o_s_wdata,
    output sw_map_pkg::slv_mask_t o_s_bready,
    input  sw_map_pkg::slv_mask_t i_s_awready,
    input  sw_map_pkg::slv_mask_t i_s_wready,
    input  sw_map_pkg::slv_mask_t i_s_bvalid,
    input  axi_chan_pkg::id_t     i_s_bid   [0:`SW_SLV_NB-1],
    input  axi_chan_pkg::resp_e   i_s_bresp [0:`SW_SLV_NB-1]
);

    logic              mr_push;
    logic              mr_full;
    axi_chan_pkg::id_t mr_id;

    slv_lane_if u_lane_if [0:`SW_SLV_NB-1] ();

    // Payload is broadcast, only the valids are steered
    assign o_s_awaddr = i_m_awaddr;
    assign o_s_awid   = i_m_awid;
    assign o_s_wdata  = i_m_wdata;

    aw_route_decode u_decode (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_awvalid (i_m_awvalid),
        .i_awaddr  (i_m_awaddr),
        .i_awid    (i_m_awid),
        .i_wvalid  (i_m_wvalid),
        .i_wlast   (i_m_wlast),
        .i_mr_full (mr_full),
        .o_awready (o_m_awready),
        .o_wready  (o_m_wready),
        .o_mr_push (mr_push),
        .o_mr_id   (mr_id),
        .lane_if   (u_lane_if)
    );

    for (genvar k = 0; k < `SW_SLV_NB; k++) begin : g_slv
        slv_lane u_lane (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .i_awready (i_s_awready[k]),
            .i_wready  (i_s_wready[k]),
            .i_bvalid  (i_s_bvalid[k]),
            .o_awvalid (o_s_awvalid[k]),
            .o_wvalid  (o_s_wvalid[k]),
            .o_wlast   (o_s_wlast[k]),
            .o_bready  (o_s_bready[k]),
            .lane_if   (u_lane_if[k])
        );
    end

    bresp_arbiter u_arbiter (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_mr_push (mr_push),
        .i_mr_id   (mr_id),
        .i_bready  (i_m_bready),
        .i_s_bid   (i_s_bid),
        .i_s_bresp (i_s_bresp),
        .o_mr_full (mr_full),
        .o_bvalid  (o_m_bvalid),
        .o_bid     (o_m_bid),
        .o_bresp   (o_m_bresp),
        .resp_if   (u_lane_if)
    );

endmodule

// File: bench/axi_wr_switch_sva.sv
////////////////////
// Handshake assertions, bound to the write switch top level
////////////////////

`timescale 1ns/100ps

module axi_wr_switch_sva (
    input logic                  aclk,
    input logic                  aresetn,
    input sw_map_pkg::slv_mask_t o_s_awvalid,
    input sw_map_pkg::slv_mask_t o_s_bready,
    input logic                  o_m_bvalid,
    input axi_chan_pkg::id_t     o_m_bid,
    input logic                  i_m_bready
);

    // Address goes to one slave at most
    a_aw_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
        $onehot0(o_s_awvalid))
        else $error("o_s_awvalid has more than one bit set");

    a_b_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
        $onehot0(o_s_bready))
        else $error("o_s_bready has more than one bit set");

    // Response held until the master takes it
    a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        o_m_bvalid && !i_m_bready |=> o_m_bvalid && $stable(o_m_bid))
        else $error("o_m_bvalid or o_m_bid changed before i_m_bready");

endmodule

bind axi_wr_switch axi_wr_switch_sva u_sva (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .o_s_awvalid (o_s_awvalid),
    .o_s_bready  (o_s_bready),
    .o_m_bvalid  (o_m_bvalid),
    .o_m_bid     (o_m_bid),
    .i_m_bready  (i_m_bready)
);

// File: bench/tb_axi_wr_switch.sv
////////////////////
// Testbench of the AXI write switch
// Reads its writes and expected responses from bench/wr_patterns.hex
////////////////////

`timescale 1ns/100ps
`include "axi_sw_settings.svh"

module tb_clkgen #(
    parameter real PERIOD = 100.0
) (
    output logic o_clk
);
    initial o_clk = 1'b0;
    always #(PERIOD / 2.0) o_clk = ~o_clk;
endmodule

module tb_axi_wr_switch;

    localparam int N_FILE  = 14;
    localparam int N_PH2   = 6;
    localparam int MAX_PAT = 32;
    localparam int TIMEOUT_CYC = 200 * (N_FILE + N_PH2);

    logic                  aclk;
    logic                  aresetn;
    logic                  m_awvalid;
    axi_chan_pkg::addr_t   m_awaddr;
    axi_chan_pkg::id_t     m_awid;
    logic                  m_wvalid;
    logic                  m_wlast;
    axi_chan_pkg::data_t   m_wdata;
    logic                  m_bready;
    logic                  m_awready;
    logic                  m_wready;
    logic                  m_bvalid;
    axi_chan_pkg::id_t     m_bid;
    axi_chan_pkg::resp_e   m_bresp;
    sw_map_pkg::slv_mask_t s_awvalid;
    axi_chan_pkg::addr_t   s_awaddr;
    axi_chan_pkg::id_t     s_awid;
    sw_map_pkg::slv_mask_t s_wvalid;
    sw_map_pkg::slv_mask_t s_wlast;
    axi_chan_pkg::data_t   s_wdata;
    sw_map_pkg::slv_mask_t s_bready;
    sw_map_pkg::slv_mask_t s_awready;
    sw_map_pkg::slv_mask_t s_wready;
    sw_map_pkg::slv_mask_t s_bvalid;
    axi_chan_pkg::id_t     s_bid   [0:`SW_SLV_NB-1];
    axi_chan_pkg::resp_e   s_bresp [0:`SW_SLV_NB-1];

    // Pattern table holds the file lines first and the credit test writes after them
    logic [63:0]         pat_raw [0:N_FILE-1];
    axi_chan_pkg::addr_t p_addr  [0:MAX_PAT-1];
    axi_chan_pkg::id_t   p_id    [0:MAX_PAT-1];
    int                  p_beats [0:MAX_PAT-1];
    axi_chan_pkg::data_t p_data  [0:MAX_PAT-1];
    int                  p_slv   [0:MAX_PAT-1];
    int                  exp_q   [0:`SW_SLV_NB-1][$];
    logic                pend    [0:15];
    axi_chan_pkg::resp_e exp_resp [0:15];
    logic                mute    [0:`SW_SLV_NB-1];
    int                  n_pat;
    int                  aw_idx;
    integer              seed;
    int                  cyc;
    int                  err_cnt;
    int                  chk_cnt;
    int                  resp_cnt;

    tb_clkgen #(.PERIOD(100.0)) u_clk (.o_clk(aclk));

    axi_wr_switch u_dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_m_awvalid (m_awvalid),
        .i_m_awaddr  (m_awaddr),
        .i_m_awid    (m_awid),
        .i_m_wvalid  (m_wvalid),
        .i_m_wlast   (m_wlast),
        .i_m_wdata   (m_wdata),
        .i_m_bready  (m_bready),
        .o_m_awready (m_awready),
        .o_m_wready  (m_wready),
        .o_m_bvalid  (m_bvalid),
        .o_m_bid     (m_bid),
        .o_m_bresp   (m_bresp),
        .o_s_awvalid (s_awvalid),
        .o_s_awaddr  (s_awaddr),
        .o_s_awid    (s_awid),
        .o_s_wvalid  (s_wvalid),
        .o_s_wlast   (s_wlast),
        .o_s_wdata   (s_wdata),
        .o_s_bready  (s_bready),
        .i_s_awready (s_awready),
        .i_s_wready  (s_wready),
        .i_s_bvalid  (s_bvalid),
        .i_s_bid     (s_bid),
        .i_s_bresp   (s_bresp)
    );

    ////////////////////
    // Checks
    ////////////////////

    task automatic report_fail(input string what);
        err_cnt++;
        $display("error: %s", what);
    endtask

    task automatic check_id(input string name, input axi_chan_pkg::id_t got,
                            input axi_chan_pkg::id_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axi_chan_pkg::resp_e got,
                              input axi_chan_pkg::resp_e exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input axi_chan_pkg::data_t got,
                              input axi_chan_pkg::data_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input axi_chan_pkg::addr_t got,
                              input axi_chan_pkg::addr_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_slv(input string name, input sw_map_pkg::slv_idx_t got,
                             input sw_map_pkg::slv_idx_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    ////////////////////
    // Master side
    ////////////////////

    // Expected slave follows the memory map and a write no slave owns expects DECERR
    task automatic add_pattern(input axi_chan_pkg::addr_t addr, input axi_chan_pkg::id_t id,
                               input int beats, input axi_chan_pkg::data_t data,
                               input axi_chan_pkg::resp_e resp);
        int slv;
        slv = -1;
        if (addr < 16'h4000 && sw_map_pkg::ROUTE_MASK[addr[13:12]])
            slv = int'(addr[13:12]);
        if ((slv < 0) != (resp == axi_chan_pkg::DECERR))
            report_fail("pattern response disagrees with the memory map");
        p_addr[n_pat]  = addr;
        p_id[n_pat]    = id;
        p_beats[n_pat] = beats;
        p_data[n_pat]  = data;
        p_slv[n_pat]   = slv;
        if (slv >= 0)
            exp_q[slv].push_back(n_pat);
        pend[id]     = 1'b1;
        exp_resp[id] = resp;
        n_pat++;
    endtask

    task automatic drive_aw(input int first, input int last);
        for (int i = first; i < last; i++) begin
            m_awvalid <= 1'b1;
            m_awaddr  <= p_addr[i];
            m_awid    <= p_id[i];
            aw_idx    <= i;
            do @(posedge aclk); while (!m_awready);
        end
        m_awvalid <= 1'b0;
    endtask

    task automatic drive_w(input int first, input int last);
        for (int i = first; i < last; i++) begin
            for (int b = 0; b < p_beats[i]; b++) begin
                m_wvalid <= 1'b1;
                m_wdata  <= p_data[i] + axi_chan_pkg::data_t'(b);
                m_wlast  <= (b == p_beats[i] - 1);
                do @(posedge aclk); while (!m_wready);
            end
        end
        m_wvalid <= 1'b0;
        m_wlast  <= 1'b0;
    endtask

    function automatic logic pend_any();
        logic any;
        any = 1'b0;
        for (int i = 0; i < 16; i++)
            any = any | pend[i];
        return any;
    endfunction

    // Each outstanding ID takes exactly one response
    always @(posedge aclk) begin
        if (aresetn && m_bvalid && m_bready) begin
            resp_cnt++;
            if (!pend[m_bid])
                report_fail("response with an ID that has no write outstanding");
            else begin
                check_resp("o_m_bresp", m_bresp, exp_resp[m_bid]);
                pend[m_bid] = 1'b0;
            end
        end
        m_bready <= ($random(seed) & 1) != 0;
    end

    always @(posedge aclk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            $display("error: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////
    // Slave models
    ////////////////////

    for (genvar k = 0; k < `SW_SLV_NB; k++) begin : g_slave
        logic              awready_r = 1'b0;
        logic              wready_r  = 1'b0;
        logic              bvalid_r  = 1'b0;
        axi_chan_pkg::id_t bid_r     = '0;
        int                wq[$];
        int                bq[$];
        int                bq_due[$];
        int                beat   = 0;
        int                outst  = 0;

        assign s_awready[k] = awready_r;
        assign s_wready[k]  = wready_r;
        assign s_bvalid[k]  = bvalid_r;
        assign s_bid[k]     = bid_r;
        assign s_bresp[k]   = axi_chan_pkg::OKAY;

        always @(posedge aclk) begin
            int idx;
            if (aresetn) begin
                awready_r <= ($random(seed) & 3) != 0;
                wready_r  <= ($random(seed) & 3) != 0;
                if (s_awvalid[k] && awready_r) begin
                    if (p_slv[aw_idx] < 0)
                        report_fail($sformatf("misrouted write reached slave %0d", k));
                    else
                        check_slv("o_s_awvalid slave", sw_map_pkg::slv_idx_t'(k),
                                  sw_map_pkg::slv_idx_t'(p_slv[aw_idx]));
                    if (exp_q[k].size() == 0)
                        report_fail($sformatf("unexpected write address at slave %0d", k));
                    else begin
                        idx = exp_q[k].pop_front();
                        check_addr("o_s_awaddr", s_awaddr, p_addr[idx]);
                        check_id("o_s_awid", s_awid, p_id[idx]);
                        wq.push_back(idx);
                    end
                    outst++;
                    if (outst > `SW_MAX_OUTST)
                        report_fail($sformatf("too many writes outstanding at slave %0d", k));
                end
                if (s_wvalid[k] && wready_r) begin
                    if (wq.size() == 0)
                        report_fail($sformatf("write data at slave %0d without address", k));
                    else begin
                        idx = wq[0];
                        check_data("o_s_wdata", s_wdata,
                                   p_data[idx] + axi_chan_pkg::data_t'(beat));
                        check_last("o_s_wlast", s_wlast[k], beat == p_beats[idx] - 1);
                        if (s_wlast[k]) begin
                            void'(wq.pop_front());
                            beat = 0;
                            bq.push_back(idx);
                            bq_due.push_back(cyc + 1 + int'($unsigned($random(seed)) % 8));
                        end else
                            beat++;
                    end
                end
                // Answer with the ID of the oldest finished write
                if (bvalid_r && s_bready[k]) begin
                    check_id("o_m_bid", m_bid, p_id[bq[0]]);
                    void'(bq.pop_front());
                    void'(bq_due.pop_front());
                    bvalid_r <= 1'b0;
                    outst--;
                end else if (!bvalid_r && bq.size() > 0 && !mute[k] && cyc >= bq_due[0]) begin
                    bvalid_r <= 1'b1;
                    bid_r    <= p_id[bq[0]];
                end
            end
        end
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        seed      = 32'h911ab11f;
        cyc       = 0;
        err_cnt   = 0;
        chk_cnt   = 0;
        resp_cnt  = 0;
        n_pat     = 0;
        aw_idx    = 0;
        aresetn   = 1'b0;
        m_awvalid = 1'b0;
        m_awaddr  = '0;
        m_awid    = '0;
        m_wvalid  = 1'b0;
        m_wlast   = 1'b0;
        m_wdata   = '0;
        m_bready  = 1'b0;
        for (int i = 0; i < 16; i++)
            pend[i] = 1'b0;
        for (int k = 0; k < `SW_SLV_NB; k++)
            mute[k] = 1'b0;

        $readmemh("bench/wr_patterns.hex", pat_raw);
        for (int i = 0; i < N_FILE; i++) begin
            if ($isunknown(pat_raw[i]))
                report_fail("pattern file has fewer lines than expected");
            else
                add_pattern(pat_raw[i][63:48], pat_raw[i][47:44], int'(pat_raw[i][43:36]),
                            pat_raw[i][35:4], axi_chan_pkg::resp_e'(pat_raw[i][1:0]));
        end

        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
        repeat (2) @(posedge aclk);

        // All slaves answer while data is held back so addresses queue up
        fork
            drive_aw(0, n_pat);
            begin
                repeat (10) @(posedge aclk);
                drive_w(0, n_pat);
            end
        join
        while (pend_any())
            @(posedge aclk);

        // Slave 2 stops answering so its fourth write must wait
        mute[2] <= 1'b1;
        add_pattern(16'h2200, 4'h1, 1, 32'h5A000001, axi_chan_pkg::OKAY);
        add_pattern(16'h2210, 4'h2, 2, 32'h5A000002, axi_chan_pkg::OKAY);
        add_pattern(16'h2220, 4'h3, 1, 32'h5A000003, axi_chan_pkg::OKAY);
        add_pattern(16'h0400, 4'h5, 1, 32'h5A000005, axi_chan_pkg::OKAY);
        add_pattern(16'h1400, 4'h6, 2, 32'h5A000006, axi_chan_pkg::OKAY);
        add_pattern(16'h2230, 4'h4, 1, 32'h5A000004, axi_chan_pkg::OKAY);
        fork
            drive_aw(N_FILE, n_pat);
            drive_w(N_FILE, n_pat);
        join_none
        while (pend[5] || pend[6])
            @(posedge aclk);
        repeat (20) @(posedge aclk);
        if (g_slave[2].outst != `SW_MAX_OUTST)
            report_fail("slave 2 does not hold the full number of outstanding writes");
        if (!pend[4] || !m_awvalid)
            report_fail("write beyond the credit limit was accepted");
        mute[2] <= 1'b0;
        wait fork;
        while (pend_any())
            @(posedge aclk);
        repeat (5) @(posedge aclk);

        $display("checks %0d, errors %0d, responses %0d", chk_cnt, err_cnt, resp_cnt);
        if (err_cnt == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: build.f
+incdir+hdl
hdl/axi_chan_pkg.sv
hdl/sw_map_pkg.sv
hdl/slv_lane_if.sv
hdl/sync_fifo.sv
hdl/aw_route_decode.sv
hdl/slv_lane.sv
hdl/bresp_arbiter.sv
hdl/axi_wr_switch.sv
bench/axi_wr_switch_sva.sv
bench/tb_axi_wr_switch.sv

// File: Makefile
TOP := tb_axi_wr_switch

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: bench/wr_patterns.hex
// One write per line: addr(4) id(1) beats(2) first data word(8) expected bresp(1)
// Beat n carries the first data word plus n, bresp 0 is OKAY and 3 is DECERR
0010002A00000000
1020104B00000100
2FF0201C00000200
3000302D00000303
0FFC403000000400
4000501E00000503
1000601111111110
2000703222222220
0200801333333330
8ABC902444444443
1FFCA02555555550
2100B04666666660
3FFCC01777777773
0300D02888888880
